/* source/seq_pkg.sv */
package seq_pkg;

    // ==================================================
    // widths
    // ==================================================

    // one instruction line, same as one host read response
    localparam int line_bits = 512;
    localparam int word_bits = 32;
    localparam int words_per_line = 16;

    // host line address, byte address minus the low bits
    localparam int host_addr_bits = 42;
    localparam int byte_idx_bits = 6;

    // 512 program lines
    localparam int prog_addr_bits = 9;

    // operator start and done lines, argument words 5 to 8
    localparam int num_ops = 6;
    localparam int num_op_args = 4;

    // ==================================================
    // encodings
    // ==================================================

    // jumps compare index n with stride2
    localparam logic [7:0] op_jump0 = 8'd0;
    localparam logic [7:0] op_jump1 = 8'd1;
    localparam logic [7:0] op_jump2 = 8'd2;

    // prefetch, load, writeback, dot, modify, update
    localparam logic [7:0] op_first_operator = 8'd10;
    localparam logic [7:0] op_last_operator = 8'd15;

    // index update codes, anything else is loaded as a value
    localparam logic [word_bits-1:0] idx_keep = 32'hFFFF_FFFF;
    localparam logic [word_bits-1:0] idx_inc = 32'h0FFF_FFFF;
    localparam logic [word_bits-1:0] idx_dec = 32'h01FF_FFFF;

    localparam logic [15:0] pc_end = 16'hFFFF;
    localparam logic [63:0] status_done = 64'd1;

    typedef enum logic [2:0]
    {
        seq_idle,
        seq_fetch,
        seq_receive,
        seq_decode,
        seq_execute,
        seq_done
    } t_seq_state;

    typedef enum logic [1:0]
    {
        load_idle,
        load_request,
        load_receive
    } t_load_state;

    // ==================================================
    // instruction line
    // ==================================================

    // raw words for storage, named fields for decode
    // word 0 in the low bits, control word 15 on top
    typedef union packed
    {
        logic [words_per_line-1:0][word_bits-1:0] words;
        struct packed
        {
            logic [word_bits-10:0] ctrl_rsvd;
            logic nonblocking;
            logic [7:0] opcode;
            logic [word_bits-1:0] jump_not_taken;
            logic [word_bits-1:0] jump_taken;
            // stride2 doubles as the jump compare value
            logic [word_bits-1:0] stride2;
            logic [word_bits-1:0] stride1;
            logic [word_bits-1:0] stride0;
            logic [word_bits-1:0] word9;
            logic [num_op_args-1:0][word_bits-1:0] args;
            logic [word_bits-1:0] length;
            logic [word_bits-1:0] base;
            logic [word_bits-1:0] idx_update2;
            logic [word_bits-1:0] idx_update1;
            logic [word_bits-1:0] idx_update0;
        } f;
    } t_instr_line;

endpackage

/* source/program_loader.sv */
`timescale 1ns/10ps

module program_loader
(
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic [seq_pkg::host_addr_bits-1:0] prog_addr,
    input  logic [15:0] prog_length,
    input  logic rd_alm_full,
    input  logic rd_rsp_valid,
    input  logic [seq_pkg::line_bits-1:0] rd_rsp_data,
    output logic rd_req_valid,
    output logic [seq_pkg::host_addr_bits-1:0] rd_req_addr,
    output logic ram_we,
    output logic [seq_pkg::prog_addr_bits-1:0] ram_waddr,
    output seq_pkg::t_instr_line ram_wdata,
    output logic prog_loaded
);

    seq_pkg::t_load_state state;

    // requests run ahead of responses
    logic [15:0] req_count;
    logic [15:0] rcv_count;
    logic last_rsp;

    // request goes out only in a cycle with almost-full low
    assign rd_req_valid = (state == seq_pkg::load_request) && !rd_alm_full;
    assign rd_req_addr = prog_addr + seq_pkg::host_addr_bits'(req_count);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= seq_pkg::load_idle;
            req_count <= '0;
            rcv_count <= '0;
            last_rsp <= 1'b0;
            ram_we <= 1'b0;
            prog_loaded <= 1'b0;
        end
        else
        begin
            ram_we <= 1'b0;
            last_rsp <= 1'b0;
            // one cycle after the last line went to the RAM
            prog_loaded <= last_rsp;

            case (state)
                seq_pkg::load_idle:
                begin
                    if (start)
                    begin
                        state <= seq_pkg::load_request;
                        req_count <= '0;
                        rcv_count <= '0;
                    end
                end

                seq_pkg::load_request:
                begin
                    if (!rd_alm_full)
                    begin
                        req_count <= req_count + 16'd1;
                        if (req_count == prog_length - 16'd1)
                        begin
                            state <= seq_pkg::load_receive;
                        end
                    end
                end

                default:
                begin
                    // all requested, only responses left
                end
            endcase

            // responses can already arrive while still requesting
            if (state != seq_pkg::load_idle && rd_rsp_valid)
            begin
                ram_we <= 1'b1;
                rcv_count <= rcv_count + 16'd1;
                if (rcv_count == prog_length - 16'd1)
                begin
                    state <= seq_pkg::load_idle;
                    last_rsp <= 1'b1;
                end
            end
        end
    end

    // write address and data, in response order
    always_ff @(posedge clk)
    begin
        if (rd_rsp_valid)
        begin
            ram_waddr <= rcv_count[seq_pkg::prog_addr_bits-1:0];
            ram_wdata.words <= rd_rsp_data;
        end
    end

endmodule

/* source/program_ram.sv */
`timescale 1ns/10ps

module program_ram
(
    input  logic clk,
    input  logic we,
    input  logic [seq_pkg::prog_addr_bits-1:0] waddr,
    input  seq_pkg::t_instr_line wdata,
    input  logic re,
    input  logic [seq_pkg::prog_addr_bits-1:0] raddr,
    output seq_pkg::t_instr_line rdata,
    output logic rvalid
);

    localparam int depth = 1 << seq_pkg::prog_addr_bits;

    seq_pkg::t_instr_line mem [depth];

    // one write port, loader side
    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem[waddr] <= wdata;
        end
    end

    // registered read, data and valid one cycle after re
    always_ff @(posedge clk)
    begin
        rvalid <= re;
        if (re)
        begin
            rdata <= mem[raddr];
        end
    end

endmodule

/* source/instr_sequencer.sv */
`timescale 1ns/10ps

module instr_sequencer
(
    input  logic clk,
    input  logic reset,
    input  logic prog_loaded,
    input  seq_pkg::t_instr_line ram_rdata,
    input  logic ram_rvalid,
    input  logic [seq_pkg::num_ops-1:0] op_done,
    output logic ram_re,
    output logic [seq_pkg::prog_addr_bits-1:0] ram_raddr,
    output logic [seq_pkg::num_ops-1:0] op_start,
    output logic [seq_pkg::word_bits-1:0] op_offset,
    output logic [seq_pkg::word_bits-1:0] op_length,
    output logic [seq_pkg::num_op_args-1:0][seq_pkg::word_bits-1:0] op_args,
    output logic done_pulse
);

    seq_pkg::t_seq_state state;
    seq_pkg::t_instr_line instr;

    logic [15:0] pc;
    logic [seq_pkg::word_bits-1:0] idx [3];

    // decode helpers
    logic is_jump;
    logic is_operator;
    logic [2:0] op_sel;
    logic [seq_pkg::word_bits-1:0] jump_idx;
    logic [seq_pkg::word_bits-1:0] strided_offset;
    logic can_advance;

    // keep, step up, step down, or load the code word itself
    function automatic logic [seq_pkg::word_bits-1:0] update_index
    (
        input logic [seq_pkg::word_bits-1:0] code,
        input logic [seq_pkg::word_bits-1:0] value
    );
        logic [seq_pkg::word_bits-1:0] result;
        case (code)
            seq_pkg::idx_keep: result = value;
            seq_pkg::idx_inc:  result = value + 32'd1;
            seq_pkg::idx_dec:  result = value - 32'd1;
            default:           result = code;
        endcase
        return result;
    endfunction

    // ==================================================
    // decode
    // ==================================================

    // which index a jump compares
    always_comb
    begin
        is_jump = 1'b1;
        jump_idx = idx[0];
        case (instr.f.opcode)
            seq_pkg::op_jump0: jump_idx = idx[0];
            seq_pkg::op_jump1: jump_idx = idx[1];
            seq_pkg::op_jump2: jump_idx = idx[2];
            default:           is_jump = 1'b0;
        endcase
    end

    assign is_operator = (instr.f.opcode >= seq_pkg::op_first_operator)
                      && (instr.f.opcode <= seq_pkg::op_last_operator);
    assign op_sel = 3'(instr.f.opcode - seq_pkg::op_first_operator);

    // base plus index times stride, over all three indices
    assign strided_offset = instr.f.base
                          + idx[0] * instr.f.stride0
                          + idx[1] * instr.f.stride1
                          + idx[2] * instr.f.stride2;

    // jumps and undefined opcodes never wait
    assign can_advance = !is_operator || instr.f.nonblocking || op_done[op_sel];

    // end of program seen in execute
    assign done_pulse = (state == seq_pkg::seq_execute) && (pc == seq_pkg::pc_end);

    // ==================================================
    // fetch, decode, execute
    // ==================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= seq_pkg::seq_idle;
            pc <= '0;
            ram_re <= 1'b0;
            op_start <= '0;
            for (int i = 0; i < 3; i++)
            begin
                idx[i] <= '0;
            end
        end
        else
        begin
            ram_re <= 1'b0;
            op_start <= '0;

            case (state)
                seq_pkg::seq_idle:
                begin
                    for (int i = 0; i < 3; i++)
                    begin
                        idx[i] <= '0;
                    end
                    pc <= '0;
                    if (prog_loaded)
                    begin
                        state <= seq_pkg::seq_fetch;
                    end
                end

                seq_pkg::seq_fetch:
                begin
                    ram_re <= 1'b1;
                    ram_raddr <= pc[seq_pkg::prog_addr_bits-1:0];
                    state <= seq_pkg::seq_receive;
                end

                seq_pkg::seq_receive:
                begin
                    if (ram_rvalid)
                    begin
                        instr <= ram_rdata;
                        state <= seq_pkg::seq_decode;
                    end
                end

                seq_pkg::seq_decode:
                begin
                    state <= seq_pkg::seq_execute;
                    if (is_jump)
                    begin
                        pc <= (jump_idx == instr.f.stride2) ? instr.f.jump_taken[15:0]
                                                            : instr.f.jump_not_taken[15:0];
                    end
                    else
                    begin
                        // operators and undefined opcodes fall through
                        pc <= pc + 16'd1;
                    end

                    if (is_operator)
                    begin
                        // start shows up in the first execute cycle
                        op_start[op_sel] <= 1'b1;
                        // prefetch, load, writeback are strided
                        op_offset <= (op_sel < 3'd3) ? strided_offset : instr.f.base;
                        op_length <= instr.f.length;
                        op_args <= instr.f.args;
                    end
                end

                seq_pkg::seq_execute:
                begin
                    if (pc == seq_pkg::pc_end)
                    begin
                        state <= seq_pkg::seq_done;
                    end
                    else if (can_advance)
                    begin
                        idx[0] <= update_index(instr.f.idx_update0, idx[0]);
                        idx[1] <= update_index(instr.f.idx_update1, idx[1]);
                        idx[2] <= update_index(instr.f.idx_update2, idx[2]);
                        state <= seq_pkg::seq_fetch;
                    end
                end

                default:
                begin
                    state <= seq_pkg::seq_idle;
                end
            endcase
        end
    end

endmodule

/* source/done_notifier.sv */
`timescale 1ns/10ps

module done_notifier
(
    input  logic clk,
    input  logic reset,
    input  logic done_pulse,
    input  logic [seq_pkg::host_addr_bits-1:0] status_addr,
    input  logic wr_alm_full,
    output logic wr_valid,
    output logic [seq_pkg::host_addr_bits-1:0] wr_addr,
    output logic [63:0] wr_data,
    output logic notify_done
);

    // status write owed to the host
    logic pending;

    // write leaves only in a cycle with almost-full low
    assign wr_valid = pending && !wr_alm_full;
    assign wr_data = seq_pkg::status_done;
    assign notify_done = wr_valid;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pending <= 1'b0;
        end
        else if (done_pulse)
        begin
            pending <= 1'b1;
        end
        else if (wr_valid)
        begin
            pending <= 1'b0;
        end
    end

    // status line captured at program end
    always_ff @(posedge clk)
    begin
        if (done_pulse)
        begin
            wr_addr <= status_addr;
        end
    end

endmodule

/* source/glm_sequencer_top.sv */
`timescale 1ns/10ps

module glm_sequencer_top
(
    input  logic clk,
    input  logic reset,

    // control register writes
    input  logic [2:0] csr_wr_en,
    input  logic [63:0] csr_wr_data,

    // host read
    output logic rd_req_valid,
    output logic [seq_pkg::host_addr_bits-1:0] rd_req_addr,
    input  logic rd_alm_full,
    input  logic rd_rsp_valid,
    input  logic [seq_pkg::line_bits-1:0] rd_rsp_data,

    // host write
    output logic wr_valid,
    output logic [seq_pkg::host_addr_bits-1:0] wr_addr,
    output logic [63:0] wr_data,
    input  logic wr_alm_full,

    // operators
    output logic [seq_pkg::num_ops-1:0] op_start,
    output logic [seq_pkg::word_bits-1:0] op_offset,
    output logic [seq_pkg::word_bits-1:0] op_length,
    output logic [seq_pkg::num_op_args-1:0][seq_pkg::word_bits-1:0] op_args,
    input  logic [seq_pkg::num_ops-1:0] op_done,

    output logic busy
);

    // ==================================================
    // control registers
    // ==================================================

    logic [seq_pkg::host_addr_bits-1:0] prog_addr;
    logic [seq_pkg::host_addr_bits-1:0] status_addr;
    logic [15:0] prog_length;
    logic start;
    logic running;
    logic notify_done;

    // byte addresses in, line addresses kept
    always_ff @(posedge clk)
    begin
        if (csr_wr_en[0])
        begin
            prog_addr <= csr_wr_data[seq_pkg::byte_idx_bits +: seq_pkg::host_addr_bits];
        end
        if (csr_wr_en[1])
        begin
            status_addr <= csr_wr_data[seq_pkg::byte_idx_bits +: seq_pkg::host_addr_bits];
        end
        // length write also kicks off a run
        if (csr_wr_en[2])
        begin
            prog_length <= csr_wr_data[15:0];
        end
    end

    // busy from start until the status write goes out
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            start <= 1'b0;
            running <= 1'b0;
        end
        else
        begin
            start <= csr_wr_en[2];
            if (start)
            begin
                running <= 1'b1;
            end
            else if (notify_done)
            begin
                running <= 1'b0;
            end
        end
    end

    assign busy = start || running;

    // ==================================================
    // blocks
    // ==================================================

    logic ram_we;
    logic [seq_pkg::prog_addr_bits-1:0] ram_waddr;
    seq_pkg::t_instr_line ram_wdata;
    logic ram_re;
    logic [seq_pkg::prog_addr_bits-1:0] ram_raddr;
    seq_pkg::t_instr_line ram_rdata;
    logic ram_rvalid;
    logic prog_loaded;
    logic done_pulse;

    program_loader program_loader_i
    (
        .clk,
        .reset,
        .start,
        .prog_addr,
        .prog_length,
        .rd_alm_full,
        .rd_rsp_valid,
        .rd_rsp_data,
        .rd_req_valid,
        .rd_req_addr,
        .ram_we,
        .ram_waddr,
        .ram_wdata,
        .prog_loaded
    );

    program_ram program_ram_i
    (
        .clk,
        .we(ram_we),
        .waddr(ram_waddr),
        .wdata(ram_wdata),
        .re(ram_re),
        .raddr(ram_raddr),
        .rdata(ram_rdata),
        .rvalid(ram_rvalid)
    );

    instr_sequencer instr_sequencer_i
    (
        .clk,
        .reset,
        .prog_loaded,
        .ram_rdata,
        .ram_rvalid,
        .op_done,
        .ram_re,
        .ram_raddr,
        .op_start,
        .op_offset,
        .op_length,
        .op_args,
        .done_pulse
    );

    done_notifier done_notifier_i
    (
        .clk,
        .reset,
        .done_pulse,
        .status_addr,
        .wr_alm_full,
        .wr_valid,
        .wr_addr,
        .wr_data,
        .notify_done
    );

endmodule

/* tb/tb_programs.svh */
// ==================================================
// instruction line builders
// ==================================================

// operator line, args are base plus 1 to 4
task automatic put_operator
(
    input int addr,
    input logic [7:0] opcode,
    input logic nb,
    input logic [31:0] base,
    input logic [31:0] len,
    input logic [31:0] s0,
    input logic [31:0] s1,
    input logic [31:0] s2,
    input logic [31:0] u0,
    input logic [31:0] u1,
    input logic [31:0] u2
);
    seq_pkg::t_instr_line line;
    line.words = '0;
    line.words[0] = u0;
    line.words[1] = u1;
    line.words[2] = u2;
    line.words[3] = base;
    line.words[4] = len;
    for (int i = 0; i < 4; i++)
    begin
        line.words[5 + i] = base + 32'(i + 1);
    end
    line.words[10] = s0;
    line.words[11] = s1;
    line.words[12] = s2;
    line.words[15] = {23'd0, nb, opcode};
    host_mem[addr] = line;
endtask

// jump on index n equal to cmp, indices kept
task automatic put_jump
(
    input int addr,
    input logic [7:0] opcode,
    input logic [31:0] cmp,
    input logic [31:0] taken,
    input logic [31:0] not_taken
);
    seq_pkg::t_instr_line line;
    line.words = '0;
    for (int i = 0; i < 3; i++)
    begin
        line.words[i] = seq_pkg::idx_keep;
    end
    line.words[12] = cmp;
    line.words[13] = taken;
    line.words[14] = not_taken;
    line.words[15] = {24'd0, opcode};
    host_mem[addr] = line;
endtask

// expected operator start
task automatic expect_op
(
    input int sel,
    input logic [31:0] off,
    input logic [31:0] len,
    input logic [31:0] base,
    input logic nb
);
    exp_sel.push_back(sel);
    exp_off.push_back(off);
    exp_len.push_back(len);
    exp_args.push_back({base + 32'd4, base + 32'd3, base + 32'd2, base + 32'd1});
    exp_nb.push_back(nb);
endtask

// six operators, first loads indices 2, 3, 4, then undefined, then end
task automatic build_straight(input int b);
    logic [31:0] off;
    put_operator(b, 8'd10, 1'b0, 32'd1000, 32'd16, 32'd1, 32'd2, 32'd3, 32'd2, 32'd3, 32'd4);
    expect_op(0, 32'd1000, 32'd16, 32'd1000, 1'b0);
    for (int k = 1; k < 6; k++)
    begin
        put_operator(b + k, 8'(10 + k), 1'b0, 32'(1000 * (k + 1)), 32'(16 + k),
                     32'(k * 3), 32'(k * 5), 32'(k * 7), seq_pkg::idx_keep,
                     seq_pkg::idx_keep, seq_pkg::idx_keep);
        // strided only for opcodes 10 to 12
        off = 32'(1000 * (k + 1));
        if (k < 3)
        begin
            off = off + 32'(2 * k * 3 + 3 * k * 5 + 4 * k * 7);
        end
        expect_op(k, off, 32'(16 + k), 32'(1000 * (k + 1)), 1'b0);
    end
    put_jump(b + 6, 8'd7, 32'd0, 32'd0, 32'd0);
    put_jump(b + 7, seq_pkg::op_jump0, 32'd0, 32'hFFFF, 32'hFFFF);
endtask

// one operator and jump0 back until index 0 reaches trips
task automatic build_loop(input int b, input int trips);
    put_operator(b, 8'd10, 1'b0, 32'd100, 32'd8, 32'd5, 32'd0, 32'd0, seq_pkg::idx_inc,
                 seq_pkg::idx_keep, seq_pkg::idx_keep);
    put_jump(b + 1, seq_pkg::op_jump0, 32'(trips), 32'd2, 32'd0);
    put_jump(b + 2, seq_pkg::op_jump0, 32'd0, 32'hFFFF, 32'hFFFF);
    for (int k = 0; k < trips; k++)
    begin
        expect_op(0, 32'(100 + 5 * k), 32'd8, 32'd100, 1'b0);
    end
endtask

// nonblocking op 1, then blocking op 2
task automatic build_overlap(input int b);
    put_operator(b, 8'd11, 1'b1, 32'd700, 32'd4, 32'd9, 32'd9, 32'd9, seq_pkg::idx_keep,
                 seq_pkg::idx_keep, seq_pkg::idx_keep);
    put_operator(b + 1, 8'd12, 1'b0, 32'd800, 32'd4, 32'd9, 32'd9, 32'd9, seq_pkg::idx_keep,
                 seq_pkg::idx_keep, seq_pkg::idx_keep);
    put_jump(b + 2, seq_pkg::op_jump0, 32'd0, 32'hFFFF, 32'hFFFF);
    expect_op(1, 32'd700, 32'd4, 32'd700, 1'b1);
    expect_op(2, 32'd800, 32'd4, 32'd800, 1'b0);
endtask

/* tb/tb_glm_sequencer.sv */
`timescale 1ns/10ps

module tb_glm_sequencer;

    localparam int total_len = 8 + 3 + 3;
    localparam int cycle_limit = total_len * 20 + 200 * 3;
    localparam int status_line = 200;

    logic clk;
    logic reset;
    logic [2:0] csr_wr_en;
    logic [63:0] csr_wr_data;
    logic rd_req_valid;
    logic [seq_pkg::host_addr_bits-1:0] rd_req_addr;
    logic rd_alm_full;
    logic rd_rsp_valid;
    logic [seq_pkg::line_bits-1:0] rd_rsp_data;
    logic wr_valid;
    logic [seq_pkg::host_addr_bits-1:0] wr_addr;
    logic [63:0] wr_data;
    logic wr_alm_full;
    logic [seq_pkg::num_ops-1:0] op_start;
    logic [seq_pkg::word_bits-1:0] op_offset;
    logic [seq_pkg::word_bits-1:0] op_length;
    logic [seq_pkg::num_op_args-1:0][seq_pkg::word_bits-1:0] op_args;
    logic [seq_pkg::num_ops-1:0] op_done;
    logic busy;

    // host memory, expected starts, bookkeeping
    logic [seq_pkg::line_bits-1:0] host_mem [256];
    int exp_sel[$];
    logic [31:0] exp_off[$];
    logic [31:0] exp_len[$];
    logic [127:0] exp_args[$];
    logic exp_nb[$];
    logic [seq_pkg::line_bits-1:0] rsp_data_q[$];
    int rsp_due_q[$];
    int cycle;
    int errors;
    int req_seen;
    int start_seen;
    int wr_seen;
    int wr_cycle;
    int exp_req_addr;
    int blocking_op;
    int nb_op;
    logic blocking_wait;
    logic nb_pending;
    logic overlap_seen;
    logic [seq_pkg::num_ops-1:0] slow_ops;
    // status write side kept full until the program has ended
    logic hold_wr;
    logic [31:0] rng;

    `include "tb_programs.svh"

    glm_sequencer_top glm_sequencer_top_i (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic report_mismatch(input string name, input logic [127:0] exp,
                                   input logic [127:0] act);
        $display("** Error at %0t ns: %s expected %0h, actual %0h", $time, name, exp, act);
        errors++;
    endtask

    task automatic report_failure(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        errors++;
    endtask

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // cycle counter and timeout
    always @(posedge clk)
    begin
        cycle <= cycle + 1;
        if (cycle >= cycle_limit)
        begin
            report_failure("run exceeded the cycle limit");
            $display("Simulation failed");
            $finish;
        end
    end

    // ==================================================
    // host and operator models
    // ==================================================

    always @(posedge clk)
    begin
        int due;
        logic [seq_pkg::num_ops-1:0] done_next;
        int cnt [seq_pkg::num_ops];
        rng = xorshift(rng);
        rd_alm_full <= (rng[2:0] == 3'd0);
        wr_alm_full <= hold_wr || (rng[5:4] == 2'd0);
        // in-order responses 2 to 5 cycles after the request
        if (!reset && rd_req_valid)
        begin
            due = cycle + 2 + int'(rng[9:8]);
            if (rsp_due_q.size() > 0 && due <= rsp_due_q[$])
            begin
                due = rsp_due_q[$] + 1;
            end
            rsp_due_q.push_back(due);
            rsp_data_q.push_back(host_mem[rd_req_addr[7:0]]);
        end
        if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cycle)
        begin
            void'(rsp_due_q.pop_front());
            rd_rsp_valid <= 1'b1;
            rd_rsp_data <= rsp_data_q.pop_front();
        end
        else
        begin
            rd_rsp_valid <= 1'b0;
        end
        // operator done 1 to 8 cycles after start, slow ones 12 more
        done_next = '0;
        for (int i = 0; i < seq_pkg::num_ops; i++)
        begin
            if (cnt[i] == 1)
            begin
                done_next[i] = 1'b1;
            end
            if (cnt[i] > 0)
            begin
                cnt[i]--;
            end
            if (!reset && op_start[i])
            begin
                rng = xorshift(rng);
                cnt[i] = 1 + int'(rng[2:0]) + (slow_ops[i] ? 12 : 0);
            end
        end
        op_done <= done_next;
    end

    // ==================================================
    // checks
    // ==================================================

    assert property (@(posedge clk) disable iff (reset) rd_req_valid |-> !rd_alm_full)
        else report_failure("read request while rd_alm_full high");
    assert property (@(posedge clk) disable iff (reset) wr_valid |-> !wr_alm_full)
        else report_failure("status write while wr_alm_full high");
    assert property (@(posedge clk) disable iff (reset) $onehot0(op_start))
        else report_failure("op_start not one-hot");

    always @(posedge clk)
    begin
        if (!reset)
        begin
            if (rd_req_valid)
            begin
                assert (rd_req_addr == seq_pkg::host_addr_bits'(exp_req_addr))
                    else report_mismatch("rd_req_addr", 128'(exp_req_addr), 128'(rd_req_addr));
                exp_req_addr++;
                req_seen++;
            end
            if (nb_pending && op_done[nb_op])
            begin
                nb_pending = 1'b0;
            end
            if (blocking_wait && op_done[blocking_op])
            begin
                blocking_wait = 1'b0;
            end
            if (op_start != '0)
            begin
                start_seen++;
                assert (!blocking_wait)
                    else report_failure("op_start before the blocking operator finished");
                if (nb_pending)
                begin
                    overlap_seen = 1'b1;
                end
                if (exp_sel.size() == 0)
                begin
                    report_failure("unexpected op_start");
                end
                else
                begin
                    assert (op_start == seq_pkg::num_ops'(1 << exp_sel[0]))
                        else report_mismatch("op_start", 128'(1 << exp_sel[0]), 128'(op_start));
                    assert (op_offset == exp_off[0])
                        else report_mismatch("op_offset", 128'(exp_off[0]), 128'(op_offset));
                    assert (op_length == exp_len[0])
                        else report_mismatch("op_length", 128'(exp_len[0]), 128'(op_length));
                    assert (op_args == exp_args[0])
                        else report_mismatch("op_args", exp_args[0], op_args);
                    if (exp_nb[0])
                    begin
                        nb_pending = 1'b1;
                        nb_op = exp_sel[0];
                    end
                    else
                    begin
                        blocking_wait = 1'b1;
                        blocking_op = exp_sel[0];
                    end
                    void'(exp_sel.pop_front());
                    void'(exp_off.pop_front());
                    void'(exp_len.pop_front());
                    void'(exp_args.pop_front());
                    void'(exp_nb.pop_front());
                end
            end
            if (wr_valid)
            begin
                wr_seen++;
                wr_cycle = cycle;
                assert (wr_addr == seq_pkg::host_addr_bits'(status_line))
                    else report_mismatch("wr_addr", 128'(status_line), 128'(wr_addr));
                assert (wr_data == 64'd1)
                    else report_mismatch("wr_data", 128'd1, 128'(wr_data));
            end
        end
    end

    // ==================================================
    // stimulus
    // ==================================================

    // load, run and check one program
    task automatic run_program(input string name, input int b, input int len,
                               input int starts);
        int errors_before;
        errors_before = errors;
        exp_req_addr = b;
        req_seen = 0;
        start_seen = 0;
        wr_seen = 0;
        overlap_seen = 1'b0;
        @(posedge clk);
        hold_wr <= 1'b1;
        csr_wr_en <= 3'b001;
        csr_wr_data <= 64'(b) << seq_pkg::byte_idx_bits;
        @(posedge clk);
        csr_wr_en <= 3'b010;
        csr_wr_data <= 64'(status_line) << seq_pkg::byte_idx_bits;
        @(posedge clk);
        csr_wr_en <= 3'b100;
        csr_wr_data <= 64'(len);
        @(posedge clk);
        csr_wr_en <= 3'b000;
        @(posedge clk);
        assert (busy) else report_failure("busy did not rise after the start write");
        // last start, then enough cycles for the closing jumps
        while (exp_sel.size() > 0)
        begin
            @(posedge clk);
        end
        repeat (40) @(posedge clk);
        hold_wr <= 1'b0;
        while (busy)
        begin
            @(posedge clk);
        end
        assert (cycle == wr_cycle + 1)
            else report_mismatch("busy fall cycle", 128'(wr_cycle + 1), 128'(cycle));
        assert (req_seen == len) else report_mismatch("read requests", 128'(len), 128'(req_seen));
        assert (start_seen == starts)
            else report_mismatch("op_start count", 128'(starts), 128'(start_seen));
        assert (wr_seen == 1) else report_mismatch("status writes", 128'd1, 128'(wr_seen));
        assert (exp_sel.size() == 0) else report_failure("operator starts missing");
        repeat (5) @(posedge clk);
        $display("test %s: %0d errors", name, errors - errors_before);
    endtask

    initial
    begin
        reset = 1'b1;
        csr_wr_en = '0;
        csr_wr_data = '0;
        rd_alm_full = 1'b0;
        rd_rsp_valid = 1'b0;
        rd_rsp_data = '0;
        wr_alm_full = 1'b0;
        op_done = '0;
        cycle = 0;
        errors = 0;
        wr_cycle = 0;
        blocking_wait = 1'b0;
        nb_pending = 1'b0;
        slow_ops = '0;
        hold_wr = 1'b0;
        rng = 32'd64909;
        for (int a = 0; a < 256; a++)
        begin
            for (int w = 0; w < 16; w++)
            begin
                host_mem[a][w * 32 +: 32] = 32'h5A00_0000 | 32'(a << 8) | 32'(w);
            end
        end
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        assert (!rd_req_valid && !wr_valid && op_start == '0 && !busy)
            else report_failure("outputs not low after reset");
        $display("test reset: %0d errors", errors);

        build_straight(16);
        run_program("dispatch", 16, 8, 6);
        build_loop(48, 4);
        run_program("loop", 48, 3, 4);
        build_overlap(80);
        slow_ops <= 6'b000010;
        run_program("nonblocking", 80, 3, 2);
        assert (overlap_seen) else report_failure("nonblocking operator did not overlap");

        $display("tests: 4, errors: %0d", errors);
        if (errors == 0)
        begin
            $display("Simulation passed");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+tb
source/seq_pkg.sv
source/program_loader.sv
source/program_ram.sv
source/instr_sequencer.sv
source/done_notifier.sv
source/glm_sequencer_top.sv
tb/tb_glm_sequencer.sv

/* Makefile */
# Verilator build and run of the sequencer testbench

VERILATOR ?= verilator
TOP ?= tb_glm_sequencer
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0 -Wno-fatal
PASS_TEXT ?= Simulation passed

.PHONY: help test build clean

help:
	@echo "targets:"
	@echo "  test   build and run the simulation, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
